/* hdl/exec_pkg.sv */
//////////////////////////////
// Execute stage package
// Unit select, operation codes, widths and the result payload
//////////////////////////////

package exec_pkg;

    localparam int XLEN  = 32;                  // Data width
    localparam int REG_W = 5;                   // Register index width

    //////////////////////////////
    // Unit select and op codes
    //////////////////////////////

    typedef enum logic [1:0] {
        UNIT_ADD    = 2'd0,                     // ADD, SUB, SLT, SLTU
        UNIT_LOGIC  = 2'd1,                     // XOR, OR, AND
        UNIT_SHIFT  = 2'd2,                     // SLL, SRL, SRA
        UNIT_BRANCH = 2'd3                      // Conditional branches, JAL, JALR
    } unit_e;

    // Meaning depends on the selected unit
    typedef enum logic [2:0] {
        OP0 = 3'd0,                             // XOR / SLL / BEQ
        OP1 = 3'd1,                             // SUB / OR / SRL / BNE
        OP2 = 3'd2,                             // SLTU / BLT
        OP3 = 3'd3,                             // SLT / BLTU
        OP4 = 3'd4,                             // BGE
        OP5 = 3'd5,                             // BGEU
        OP6 = 3'd6,                             // JAL
        OP7 = 3'd7                              // JALR
    } op_e;

    //////////////////////////////
    // Result payload
    //////////////////////////////

    // 71 bits, one entry of the result FIFO
    typedef struct packed {
        logic [REG_W-1:0] rd;                   // Destination index
        logic [XLEN-1:0]  value;                // Write-back value
        logic             wb;                   // Write request
        logic             jump;                 // Taken jump or branch
        logic [XLEN-1:0]  target;               // Branch target
    } exec_result_t;

endpackage

/* hdl/exec_dispatch.sv */
//////////////////////////////
// Execute stage dispatch
// Registers one issued instruction and presents it
// to the execution units for a single cycle
//////////////////////////////

module exec_dispatch (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       issue,       // One-cycle strobe
    input  exec_pkg::unit_e            unit,
    input  exec_pkg::op_e              op,
    input  logic [exec_pkg::XLEN-1:0]  op_a,
    input  logic [exec_pkg::XLEN-1:0]  op_b,
    input  logic [exec_pkg::XLEN-1:0]  imm,
    input  logic [exec_pkg::XLEN-1:0]  pc,
    input  logic [exec_pkg::REG_W-1:0] rd,
    input  logic                       busy,        // FIFO almost full
    output logic                       ex_valid,    // FIFO push
    output exec_pkg::unit_e            ex_unit,
    output exec_pkg::op_e              ex_op,
    output logic [exec_pkg::XLEN-1:0]  ex_a,
    output logic [exec_pkg::XLEN-1:0]  ex_b,
    output logic [exec_pkg::XLEN-1:0]  ex_imm,
    output logic [exec_pkg::XLEN-1:0]  ex_pc,
    output logic [exec_pkg::REG_W-1:0] ex_rd
);

    //////////////////////////////
    // Valid strobe
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue;                      // High for exactly one cycle
        end
    end

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    // Fields only move on issue, units see stable inputs in between
    always_ff @(posedge clk) begin
        if (issue) begin
            ex_unit <= unit;
            ex_op   <= op;
            ex_a    <= op_a;
            ex_b    <= op_b;
            ex_imm  <= imm;
            ex_pc   <= pc;
            ex_rd   <= rd;                          // Destination travels with result
        end
    end

    // The slot held here relies on busy rising one entry early in the FIFO
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!arst_n)
        issue |-> !busy)
        else $error("Issue while busy");

endmodule

/* hdl/exec_units.sv */
//////////////////////////////
// Execution units
// Adder, logic, shifter and branch unit, all combinational,
// plus assembly of the result payload
//////////////////////////////

module exec_units (
    input  exec_pkg::unit_e            ex_unit,
    input  exec_pkg::op_e              ex_op,
    input  logic [exec_pkg::XLEN-1:0]  ex_a,
    input  logic [exec_pkg::XLEN-1:0]  ex_b,
    input  logic [exec_pkg::XLEN-1:0]  ex_imm,
    input  logic [exec_pkg::XLEN-1:0]  ex_pc,
    input  logic [exec_pkg::REG_W-1:0] ex_rd,
    output exec_pkg::exec_result_t     res_payload
);

    import exec_pkg::*;

    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] logic_res;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] br_sum;                        // opA + opB for jumps
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] link;                          // PC+4
    logic            br_jump;
    logic            is_jal;

    //////////////////////////////
    // Adder
    //////////////////////////////

    always_comb begin
        if (ex_op == OP3) begin
            add_res = {{(XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};     // SLT
        end else if (ex_op == OP2) begin
            add_res = {{(XLEN-1){1'b0}}, ex_a < ex_b};                       // SLTU
        end else if (ex_op == OP1) begin
            add_res = ex_a - ex_b;                  // SUB
        end else begin
            add_res = ex_a + ex_b;                  // ADD
        end
    end

    //////////////////////////////
    // Logic and shifter
    //////////////////////////////

    always_comb begin
        case (ex_op)
            OP0:     logic_res = ex_a ^ ex_b;       // XOR
            OP1:     logic_res = ex_a | ex_b;       // OR
            default: logic_res = ex_a & ex_b;       // AND
        endcase
    end

    // Shift amount is the low 5 bits of opB
    always_comb begin
        case (ex_op)
            OP0:     shift_res = ex_a << ex_b[4:0];             // SLL
            OP1:     shift_res = ex_a >> ex_b[4:0];             // SRL
            default: shift_res = $signed(ex_a) >>> ex_b[4:0];   // SRA
        endcase
    end

    //////////////////////////////
    // Branch unit
    //////////////////////////////

    assign br_sum = ex_a + ex_b;
    assign link   = ex_pc + XLEN'(4);
    assign is_jal = (ex_op == OP6) || (ex_op == OP7);

    always_comb begin
        case (ex_op)
            OP6:     br_target = br_sum;                    // JAL
            OP7:     br_target = {br_sum[XLEN-1:1], 1'b0};  // JALR, bit 0 cleared
            default: br_target = ex_pc + ex_imm;            // Conditional, PC + offset
        endcase
    end

    always_comb begin
        case (ex_op)
            OP0:     br_jump = (ex_a == ex_b);                  // BEQ
            OP1:     br_jump = (ex_a != ex_b);                  // BNE
            OP2:     br_jump = ($signed(ex_a) < $signed(ex_b)); // BLT
            OP3:     br_jump = (ex_a < ex_b);                   // BLTU
            OP4:     br_jump = ($signed(ex_a) >= $signed(ex_b));// BGE
            OP5:     br_jump = (ex_a >= ex_b);                  // BGEU
            default: br_jump = 1'b1;                            // JAL, JALR
        endcase
    end

    //////////////////////////////
    // Payload assembly
    //////////////////////////////

    always_comb begin
        res_payload.rd     = ex_rd;
        res_payload.wb     = 1'b1;                  // Default for ALU ops
        res_payload.jump   = 1'b0;
        res_payload.target = '0;                    // Only branches carry a target
        case (ex_unit)
            UNIT_ADD:   res_payload.value = add_res;
            UNIT_LOGIC: res_payload.value = logic_res;
            UNIT_SHIFT: res_payload.value = shift_res;
            default: begin
                res_payload.value  = link;          // Link value
                res_payload.wb     = is_jal;        // No write for conditional branches
                res_payload.jump   = br_jump;
                res_payload.target = br_target;
            end
        endcase
    end

endmodule

/* hdl/result_fifo.sv */
//////////////////////////////
// Result FIFO
// Synchronous circular buffer, payload type is a parameter
//////////////////////////////

module result_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,                          // Oldest entry
    output logic     empty,
    output logic     almost_full                    // DEPTH-1 or more entries
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                        // Occupancy
    logic             full;

    // Wraps at DEPTH, works for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither
            endcase
        end
    end

    assign head        = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (count >= CNT_W'(DEPTH - 1));

    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full) else $error("Push into full FIFO");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> !empty) else $error("Pop from empty FIFO");

endmodule

/* hdl/exec_retire.sv */
//////////////////////////////
// Execute stage retire
// Drains the result FIFO, writes the register file
// and signals write-back and redirect
//////////////////////////////

module exec_retire (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       hold,            // Level, stops pops
    input  logic                       empty,
    input  exec_pkg::exec_result_t     head,
    output logic                       pop,
    output logic                       wb_valid,
    output logic [exec_pkg::REG_W-1:0] wb_rd,
    output logic [exec_pkg::XLEN-1:0]  wb_data,
    output logic                       redirect,
    output logic [exec_pkg::XLEN-1:0]  redirect_target,
    input  logic [exec_pkg::REG_W-1:0] rf_raddr,
    output logic [exec_pkg::XLEN-1:0]  rf_rdata
);

    import exec_pkg::*;

    logic [XLEN-1:0] rf [32];                       // x0 never written

    assign pop = !empty && !hold;

    //////////////////////////////
    // Strobes and report
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            redirect <= 1'b0;
        end else begin
            wb_valid <= pop && head.wb;             // Includes rd == 0
            redirect <= pop && head.jump;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wb_rd           <= head.rd;
            wb_data         <= head.value;
            redirect_target <= head.target;
        end
    end

    //////////////////////////////
    // Register file
    //////////////////////////////

    // Registers start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (pop && head.wb && (head.rd != '0)) begin
            rf[head.rd] <= head.value;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];    // x0 reads zero

endmodule

/* hdl/exec_stage.sv */
//////////////////////////////
// Integer execute stage top
// Dispatch, units, result FIFO and retire
//////////////////////////////

module exec_stage #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       issue,
    input  exec_pkg::unit_e            unit,
    input  exec_pkg::op_e              op,
    input  logic [exec_pkg::XLEN-1:0]  op_a,
    input  logic [exec_pkg::XLEN-1:0]  op_b,
    input  logic [exec_pkg::XLEN-1:0]  imm,
    input  logic [exec_pkg::XLEN-1:0]  pc,
    input  logic [exec_pkg::REG_W-1:0] rd,
    input  logic                       hold,
    output logic                       busy,
    output logic                       wb_valid,
    output logic [exec_pkg::REG_W-1:0] wb_rd,
    output logic [exec_pkg::XLEN-1:0]  wb_data,
    output logic                       redirect,
    output logic [exec_pkg::XLEN-1:0]  redirect_target,
    input  logic [exec_pkg::REG_W-1:0] rf_raddr,
    output logic [exec_pkg::XLEN-1:0]  rf_rdata
);

    import exec_pkg::*;

    logic             ex_valid;                     // FIFO push
    unit_e            ex_unit;
    op_e              ex_op;
    logic [XLEN-1:0]  ex_a;
    logic [XLEN-1:0]  ex_b;
    logic [XLEN-1:0]  ex_imm;
    logic [XLEN-1:0]  ex_pc;
    logic [REG_W-1:0] ex_rd;
    exec_result_t     res_payload;
    exec_result_t     head;
    logic             empty;
    logic             pop;

    exec_dispatch exec_dispatch_i (
        .clk(clk), .arst_n(arst_n), .issue(issue), .unit(unit), .op(op),
        .op_a(op_a), .op_b(op_b), .imm(imm), .pc(pc), .rd(rd), .busy(busy),
        .ex_valid(ex_valid), .ex_unit(ex_unit), .ex_op(ex_op), .ex_a(ex_a),
        .ex_b(ex_b), .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rd(ex_rd)
    );

    exec_units exec_units_i (
        .ex_unit(ex_unit), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rd(ex_rd), .res_payload(res_payload)
    );

    // Almost full doubles as busy, leaving room for the dispatch slot
    result_fifo #(
        .DEPTH(FIFO_DEPTH),
        .payload_t(exec_result_t)
    ) result_fifo_i (
        .clk(clk), .arst_n(arst_n), .push(ex_valid), .push_data(res_payload),
        .pop(pop), .head(head), .empty(empty), .almost_full(busy)
    );

    exec_retire exec_retire_i (
        .clk(clk), .arst_n(arst_n), .hold(hold), .empty(empty), .head(head),
        .pop(pop), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .redirect(redirect), .redirect_target(redirect_target),
        .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
    );

endmodule

/* dv/exec_model.svh */
//////////////////////////////
// Execute stage reference model
// Expected value, write request, jump and target
// per instruction, plus a model register file
//////////////////////////////

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [XLEN-1:0] model_rf [32];                     // x0 stays zero

// Signed less-than from the sign bits
function automatic logic model_lt_s(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    if (a[XLEN-1] != b[XLEN-1]) begin
        return a[XLEN-1];                           // Negative side is smaller
    end
    return a < b;                                   // Same sign, plain compare
endfunction

function automatic logic [XLEN-1:0] model_value(input unit_e u, input op_e o,
        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] pc_v);
    logic [2*XLEN-1:0] ext;
    ext = {{XLEN{a[XLEN-1]}}, a} >> b[4:0];         // SRA as a wide logical shift
    case (u)
        UNIT_ADD: begin
            case (o)
                OP1:     return a - b;
                OP2:     return XLEN'(a < b);
                OP3:     return XLEN'(model_lt_s(a, b));
                default: return a + b;
            endcase
        end
        UNIT_LOGIC: begin
            case (o)
                OP0:     return a ^ b;
                OP1:     return a | b;
                default: return a & b;
            endcase
        end
        UNIT_SHIFT: begin
            case (o)
                OP0:     return a << b[4:0];
                OP1:     return a >> b[4:0];
                default: return ext[XLEN-1:0];
            endcase
        end
        default: return pc_v + XLEN'(4);            // Link value
    endcase
endfunction

function automatic logic model_wb(input unit_e u, input op_e o);
    return (u != UNIT_BRANCH) || (o == OP6) || (o == OP7);
endfunction

function automatic logic model_jump(input unit_e u, input op_e o,
        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    if (u != UNIT_BRANCH) begin
        return 1'b0;
    end
    case (o)
        OP0:     return a == b;                     // BEQ
        OP1:     return a != b;                     // BNE
        OP2:     return model_lt_s(a, b);           // BLT
        OP3:     return a < b;                      // BLTU
        OP4:     return !model_lt_s(a, b);          // BGE
        OP5:     return !(a < b);                   // BGEU
        default: return 1'b1;                       // JAL, JALR
    endcase
endfunction

function automatic logic [XLEN-1:0] model_target(input op_e o, input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm_v, input logic [XLEN-1:0] pc_v);
    case (o)
        OP6:     return a + b;
        OP7:     return (a + b) & ~XLEN'(1);        // Bit 0 cleared
        default: return pc_v + imm_v;
    endcase
endfunction

`endif

/* dv/exec_stage_tb.sv */
//////////////////////////////
// Execute stage testbench
// Random instructions against a reference model, with
// back-pressure, latency and register file checks
//////////////////////////////

module exec_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int LIMIT      = 200;                // Cycles allowed per wait

    logic             clk = 1'b0;
    logic             arst_n;
    logic             issue;
    unit_e            unit;
    op_e              op;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  imm;
    logic [XLEN-1:0]  pc;
    logic [REG_W-1:0] rd;
    logic             hold;
    logic             busy;
    logic             wb_valid;
    logic [REG_W-1:0] wb_rd;
    logic [XLEN-1:0]  wb_data;
    logic             redirect;
    logic [XLEN-1:0]  redirect_target;
    logic [REG_W-1:0] rf_raddr;
    logic [XLEN-1:0]  rf_rdata;

    `include "exec_model.svh"

    unit_e            nxt_unit;                     // Next instruction to issue
    op_e              nxt_op;
    logic [XLEN-1:0]  nxt_a;
    logic [XLEN-1:0]  nxt_b;
    logic [XLEN-1:0]  nxt_imm;
    logic [XLEN-1:0]  nxt_pc;
    logic [REG_W-1:0] nxt_rd;
    logic [REG_W-1:0] exp_rd_q [$];                 // Expected write-backs, in order
    logic [XLEN-1:0]  exp_data_q [$];
    logic [XLEN-1:0]  exp_target_q [$];             // Expected redirects
    logic [31:0]      r;
    integer           seed;
    int               errors;
    int               checks;
    int               timeouts;
    int               issue_count;
    int               hold_issues;
    int               buffered;                     // Entries pushed under hold
    int               n;
    logic             hold_req;
    logic             busy_seen;                    // Sampled at the falling edge
    logic             wb_seen;
    logic             issued;
    logic             issued_d1;
    logic             issued_d2;

    exec_stage #(.FIFO_DEPTH(FIFO_DEPTH)) exec_stage_i (.*);

    always #20 clk = ~clk;                          // 40 ns period

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_wb(input logic [REG_W-1:0] rd_got, input logic [REG_W-1:0] rd_exp,
            input logic [XLEN-1:0] data_got, input logic [XLEN-1:0] data_exp);
        checks++;
        if (rd_got !== rd_exp) begin
            errors++;
            $display("** Error at %0t: wb_rd = %0d, expected %0d", $time, rd_got, rd_exp);
        end
        if (data_got !== data_exp) begin
            errors++;
            $display("** Error at %0t: wb_data = %h, expected %h", $time, data_got, data_exp);
        end
    endtask

    task automatic check_redirect(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: redirect_target = %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_rf(input logic [REG_W-1:0] idx, input logic [XLEN-1:0] got,
            input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: rf_rdata[%0d] = %h, expected %h", $time, idx, got, exp);
        end
    endtask

    //////////////////////////////
    // Stimulus and sampling
    //////////////////////////////

    task automatic check_outputs();
        if (wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("Write-back to x%0d at %0t with nothing outstanding", wb_rd, $time);
            end else begin
                check_wb(wb_rd, exp_rd_q.pop_front(), wb_data, exp_data_q.pop_front());
            end
        end
        if (redirect) begin
            if (exp_target_q.size() == 0) begin
                errors++;
                $display("Redirect at %0t with no taken jump outstanding", $time);
            end else begin
                check_redirect(redirect_target, exp_target_q.pop_front());
            end
        end
    endtask

    task automatic record_expected();
        logic [XLEN-1:0] value;
        value = model_value(nxt_unit, nxt_op, nxt_a, nxt_b, nxt_pc);
        if (model_wb(nxt_unit, nxt_op)) begin
            exp_rd_q.push_back(nxt_rd);
            exp_data_q.push_back(value);
            if (nxt_rd != '0) begin
                model_rf[nxt_rd] = value;
            end
        end
        if (model_jump(nxt_unit, nxt_op, nxt_a, nxt_b)) begin
            exp_target_q.push_back(model_target(nxt_op, nxt_a, nxt_b, nxt_imm, nxt_pc));
        end
        issue_count++;
    endtask

    // One clock, sample at the falling edge and drive at the rising edge
    task automatic step(input logic want);
        @(negedge clk);
        busy_seen = busy;
        wb_seen   = wb_valid;
        check_outputs();
        @(posedge clk);
        // An issue from two edges back still pushes at the next edge, unseen by busy
        issued = want && !busy_seen && !issued_d2;
        hold  <= hold_req;
        issue <= issued;
        if (issued) begin
            unit <= nxt_unit;
            op   <= nxt_op;
            op_a <= nxt_a;
            op_b <= nxt_b;
            imm  <= nxt_imm;
            pc   <= nxt_pc;
            rd   <= nxt_rd;
            record_expected();
        end
        issued_d2 = issued_d1;
        issued_d1 = issued;
    endtask

    task automatic set_instr(input unit_e u, input op_e o, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [REG_W-1:0] d);
        nxt_unit = u;
        nxt_op   = o;
        nxt_a    = a;
        nxt_b    = b;
        nxt_imm  = 32'h0000_0040;
        nxt_pc   = 32'h0000_1000;
        nxt_rd   = d;
    endtask

    // Extremes for the signed and unsigned compares
    task automatic pick_operand(output logic [XLEN-1:0] v);
        logic [31:0] s;
        s = $random(seed);
        case (s[2:0])
            3'd0:    v = '0;
            3'd1:    v = 32'h7fff_ffff;
            3'd2:    v = 32'h8000_0000;
            3'd3:    v = 32'hffff_ffff;
            3'd4:    v = 32'd1;
            default: v = $random(seed);
        endcase
    endtask

    task automatic pick_random();
        logic [31:0] v;
        v = $random(seed);
        nxt_unit = unit_e'(v[1:0]);
        nxt_op   = op_e'(v[4:2]);
        nxt_rd   = v[9:5];
        pick_operand(nxt_a);
        pick_operand(nxt_b);
        if (v[12:10] == 3'd0) begin
            nxt_b = nxt_a;                          // Equal operands for BEQ and BGE
        end
        v = $random(seed);
        nxt_pc  = {v[XLEN-1:2], 2'b00};
        v = $random(seed);
        nxt_imm = {{19{v[12]}}, v[12:1], 1'b0};     // Branch offset range
    endtask

    task automatic issue_now();
        int k;
        k = 0;
        step(1'b1);
        while (!issued && k < LIMIT) begin
            step(1'b1);
            k++;
        end
        if (!issued) begin
            timeouts++;
            $display("Timed out at %0t waiting to issue an instruction", $time);
        end
    endtask

    task automatic wait_drained();
        int k;
        k = 0;
        while ((exp_rd_q.size() + exp_target_q.size()) != 0 && k < LIMIT) begin
            step(1'b0);
            k++;
        end
        if ((exp_rd_q.size() + exp_target_q.size()) != 0) begin
            timeouts++;
            $display("Timed out at %0t with %0d write-backs and %0d redirects missing",
                     $time, exp_rd_q.size(), exp_target_q.size());
        end
        for (k = 0; k < 4; k++) begin
            step(1'b0);                             // Untaken branches leave no trace
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        seed        = 14;
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        issue_count = 0;
        arst_n      = 1'b0;
        issue       = 1'b0;
        unit        = UNIT_ADD;
        op          = OP0;
        op_a        = '0;
        op_b        = '0;
        imm         = '0;
        pc          = '0;
        rd          = '0;
        hold        = 1'b0;
        rf_raddr    = '0;
        hold_req    = 1'b0;
        issued      = 1'b0;
        issued_d1   = 1'b0;
        issued_d2   = 1'b0;
        foreach (model_rf[i]) begin
            model_rf[i] = '0;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // Lone issue into an empty FIFO
        set_instr(UNIT_ADD, OP0, 32'd7, 32'd5, 5'd3);
        issue_now();
        n = 0;
        step(1'b0);
        while (!wb_seen && n < LIMIT) begin
            step(1'b0);
            n++;
        end
        if (n != 3) begin
            errors++;
            $display("Write-back came %0d cycles after a lone issue instead of 3", n);
        end

        set_instr(UNIT_ADD, OP0, 32'd5, 32'd6, 5'd0);              // Aimed at x0
        issue_now();
        set_instr(UNIT_BRANCH, OP7, 32'h0000_1001, 32'd2, 5'd1);   // JALR, odd sum
        issue_now();
        set_instr(UNIT_BRANCH, OP6, 32'h0000_2000, 32'd8, 5'd2);   // JAL
        issue_now();
        set_instr(UNIT_BRANCH, OP2, 32'h8000_0000, 32'd1, 5'd4);   // BLT taken
        issue_now();
        set_instr(UNIT_BRANCH, OP3, 32'h8000_0000, 32'd1, 5'd4);   // BLTU not taken
        issue_now();

        // Random mix with occasional hold
        for (int i = 0; i < 400; i++) begin
            pick_random();
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                hold_req = !hold_req;
            end
            step(r[4] | r[5]);
        end
        hold_req = 1'b0;
        wait_drained();

        // Fill under hold, busy follows the number of buffered results
        hold_req    = 1'b1;
        hold_issues = 0;
        n           = 0;
        busy_seen   = 1'b0;
        while (!busy_seen && n < LIMIT) begin
            pick_random();
            // Issues from the last two edges are not in the FIFO yet
            buffered = hold_issues - int'(issued_d1) - int'(issued_d2);
            step(1'b1);
            if (busy_seen !== (buffered >= FIFO_DEPTH - 1)) begin
                errors++;
                $display("** Error at %0t: busy = %0b, expected %0b", $time, busy_seen,
                         buffered >= FIFO_DEPTH - 1);
            end
            if (issued) begin
                hold_issues++;
            end
            n++;
        end
        if (!busy_seen) begin
            timeouts++;
            $display("Timed out at %0t waiting for busy under hold", $time);
        end
        for (int i = 0; i < 4; i++) begin
            step(1'b0);
            if (wb_seen || !busy_seen) begin
                errors++;
                $display("FIFO drained or busy fell at %0t while hold was high", $time);
            end
        end
        hold_req = 1'b0;
        wait_drained();

        // Register file against the model, x0 included
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rf_raddr <= REG_W'(i);
            @(negedge clk);
            check_rf(REG_W'(i), rf_rdata, (i == 0) ? XLEN'(0) : model_rf[i]);
        end

        $display("Issued: %0d, checks: %0d, errors: %0d, timeouts: %0d",
                 issue_count, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* exec_stage.f */
+incdir+dv
hdl/exec_pkg.sv
hdl/exec_dispatch.sv
hdl/exec_units.sv
hdl/result_fifo.sv
hdl/exec_retire.sv
hdl/exec_stage.sv
dv/exec_stage_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := exec_stage_tb
FLIST     := exec_stage.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
